// File: hdl/core_pkg.sv
package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and counts
    //////////////////////////////////////////////////////////////////////
    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int imm_width  = 12;
    localparam int mul_cycles = 32;                 // One product bit per cycle
    localparam int mul_cnt_w  = $clog2(mul_cycles);

    typedef logic [4:0]           reg_addr_t;
    typedef logic [xlen-1:0]      word_t;
    typedef logic [mul_cnt_w-1:0] mul_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,                                        // Signed compare
        MUL                                         // Low half of product
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        alu_op_e                op;
        reg_addr_t              rd;
        reg_addr_t              rs1;
        reg_addr_t              rs2;
        logic [imm_width-1:0]   imm;                // Sign-extended in execute
        logic                   use_imm;
    } instr_t;

    typedef struct packed {
        logic       en;
        reg_addr_t  addr;
        word_t      data;
    } fwd_t;

    typedef struct packed {
        reg_addr_t  rd;
        word_t      data;
    } result_t;

    typedef struct packed {
        word_t      rs1_data;
        word_t      rs2_data;
        logic       rs1_valid;
        logic       rs2_valid;
        instr_t     instr;
    } operands_t;

endpackage

// File: hdl/reg_file_fwd.sv
`timescale 1ns/100ps

module reg_file_fwd (
    input  logic                CLK,
    input  logic                RST,
    input  logic                stall,
    input  logic                hold,

    input  core_pkg::instr_t    instr,

    input  core_pkg::fwd_t      exec_fwd,
    input  core_pkg::fwd_t      cushion_fwd,
    input  core_pkg::fwd_t      wb_fwd,

    output core_pkg::operands_t operands
);

    //////////////////////////////////////////////////////////////////////
    // Instruction capture
    //////////////////////////////////////////////////////////////////////
    core_pkg::instr_t instr_q;

    // Forwarding sources are read live, so a stalled instruction keeps
    // tracking the later stages while its own fields stay put
    always_ff @(posedge CLK) begin
        if (RST) begin
            instr_q <= '0;                          // Both sources point at x0
        end else if (!stall && !hold) begin
            instr_q <= instr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register array
    //////////////////////////////////////////////////////////////////////
    core_pkg::word_t regs [core_pkg::reg_count];

    always_ff @(posedge CLK) begin
        if (wb_fwd.en && (wb_fwd.addr != '0)) begin // x0 is never written
            regs[wb_fwd.addr] <= wb_fwd.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand resolution
    //////////////////////////////////////////////////////////////////////

    // Only the execute stage can hold an unfinished producer
    function automatic logic operand_valid(
        input core_pkg::reg_addr_t target,
        input core_pkg::fwd_t      ex
    );
        if (target == '0) begin
            return 1'b1;
        end else if (target == ex.addr) begin
            return ex.en;
        end
        return 1'b1;
    endfunction

    function automatic core_pkg::word_t operand_data(
        input core_pkg::reg_addr_t target,
        input core_pkg::word_t     array_data,
        input core_pkg::fwd_t      ex,
        input core_pkg::fwd_t      cush,
        input core_pkg::fwd_t      wb
    );
        if (target == '0) begin
            return '0;
        end else if (target == ex.addr) begin   // Bubble carries addr 0
            return ex.data;
        end else if (cush.en && (target == cush.addr)) begin
            return cush.data;
        end else if (wb.en && (target == wb.addr)) begin
            return wb.data;                     // Array write still pending
        end
        return array_data;
    endfunction

    core_pkg::word_t rs1_array;
    core_pkg::word_t rs2_array;

    assign rs1_array = regs[instr_q.rs1];
    assign rs2_array = regs[instr_q.rs2];

    always_comb begin
        operands.instr     = instr_q;
        operands.rs1_valid = operand_valid(instr_q.rs1, exec_fwd);
        operands.rs2_valid = operand_valid(instr_q.rs2, exec_fwd);
        operands.rs1_data  = operand_data(instr_q.rs1, rs1_array,
                                          exec_fwd, cushion_fwd, wb_fwd);
        operands.rs2_data  = operand_data(instr_q.rs2, rs2_array,
                                          exec_fwd, cushion_fwd, wb_fwd);
    end

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic                CLK,
    input  logic                RST,
    input  logic                stall,
    input  logic                hold,

    input  logic                read_valid,
    input  core_pkg::operands_t operands,

    output core_pkg::fwd_t      exec_fwd,
    output core_pkg::result_t   ex_result,
    output logic                ex_done,
    output logic                busy
);

    //////////////////////////////////////////////////////////////////////
    // Execute stage register and multiplier state
    //////////////////////////////////////////////////////////////////////
    logic                ex_valid;
    core_pkg::reg_addr_t ex_rd;
    core_pkg::alu_op_e   ex_op;
    core_pkg::word_t     ex_a;
    core_pkg::word_t     ex_b;

    core_pkg::word_t     mul_acc;
    core_pkg::word_t     mul_mcand;
    core_pkg::word_t     mul_mplier;
    core_pkg::mul_cnt_t  mul_cnt;

    core_pkg::word_t     imm_ext;
    core_pkg::word_t     op_b;

    assign imm_ext = {{(core_pkg::xlen - core_pkg::imm_width){operands.instr.imm[11]}},
                      operands.instr.imm};
    assign op_b    = operands.instr.use_imm ? imm_ext : operands.rs2_data;

    always_ff @(posedge CLK) begin
        if (RST) begin
            ex_valid <= 1'b0;
            ex_rd    <= '0;
            busy     <= 1'b0;
            mul_cnt  <= '0;
        end else if (!hold) begin
            if (busy) begin
                mul_cnt <= mul_cnt + 1'b1;
                if (mul_cnt == core_pkg::mul_cnt_t'(core_pkg::mul_cycles - 1)) begin
                    busy <= 1'b0;                   // Product ready next cycle
                end
            end else if (stall) begin
                ex_valid <= 1'b0;                   // Bubble
                ex_rd    <= '0;
            end else begin
                ex_valid <= read_valid;
                ex_rd    <= read_valid ? operands.instr.rd : '0;
                busy     <= read_valid && (operands.instr.op == core_pkg::MUL);
                mul_cnt  <= '0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            if (busy) begin
                if (mul_mplier[0]) begin
                    mul_acc <= mul_acc + mul_mcand;
                end
                mul_mcand  <= mul_mcand << 1;
                mul_mplier <= mul_mplier >> 1;
            end else if (!stall) begin
                ex_op      <= operands.instr.op;
                ex_a       <= operands.rs1_data;
                ex_b       <= op_b;
                mul_acc    <= '0;
                mul_mcand  <= operands.rs1_data;
                mul_mplier <= op_b;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ALU and result
    //////////////////////////////////////////////////////////////////////
    core_pkg::word_t alu_res;
    core_pkg::word_t ex_data;

    always_comb begin
        unique case (ex_op)
            core_pkg::ADD: alu_res = ex_a + ex_b;
            core_pkg::SUB: alu_res = ex_a - ex_b;
            core_pkg::AND: alu_res = ex_a & ex_b;
            core_pkg::OR:  alu_res = ex_a | ex_b;
            core_pkg::XOR: alu_res = ex_a ^ ex_b;
            core_pkg::SLL: alu_res = ex_a << ex_b[4:0];
            core_pkg::SRL: alu_res = ex_a >> ex_b[4:0];
            core_pkg::SLT: alu_res = core_pkg::word_t'($signed(ex_a) < $signed(ex_b));
            default:       alu_res = '0;            // MUL comes from the accumulator
        endcase
    end

    assign ex_data   = (ex_op == core_pkg::MUL) ? mul_acc : alu_res;
    assign ex_done   = ex_valid && !busy;
    assign ex_result = '{rd: ex_rd, data: ex_data};
    assign exec_fwd  = '{en: ex_done, addr: ex_rd, data: ex_data};

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
    input  logic                CLK,
    input  logic                RST,
    input  logic                hold,

    input  core_pkg::result_t   ex_result,
    input  logic                ex_done,

    output core_pkg::fwd_t      cushion_fwd,
    output core_pkg::fwd_t      wb_fwd,

    output logic                out_valid,
    input  logic                out_ready,
    output core_pkg::result_t   out_result,
    output logic                full
);

    //////////////////////////////////////////////////////////////////////
    // Cushion register and output buffer
    //////////////////////////////////////////////////////////////////////
    logic              cush_valid;
    core_pkg::result_t cush_res;
    logic              move;
    logic              wb_en;

    // Buffer is free or draining whenever hold is low
    assign move = !hold && cush_valid;

    always_ff @(posedge CLK) begin
        if (RST) begin
            cush_valid <= 1'b0;
            out_valid  <= 1'b0;
            wb_en      <= 1'b0;
        end else begin
            wb_en <= move;                          // One write per retired result
            if (!hold) begin
                cush_valid <= ex_done;
                out_valid  <= cush_valid;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold && ex_done) begin
            cush_res <= ex_result;
        end
        if (move) begin
            out_result <= cush_res;
        end
    end

    assign full        = out_valid && !out_ready;
    assign cushion_fwd = '{en: cush_valid, addr: cush_res.rd, data: cush_res.data};
    assign wb_fwd      = '{en: wb_en, addr: out_result.rd, data: out_result.data};

endmodule

// File: hdl/stage_ctrl.sv
`timescale 1ns/100ps

module stage_ctrl (
    input  logic CLK,
    input  logic RST,

    input  logic in_valid,
    output logic in_ready,

    input  logic operands_ok,
    input  logic busy,
    input  logic full,
    input  logic out_ready,

    output logic stall,
    output logic hold,
    output logic read_valid
);

    //////////////////////////////////////////////////////////////////////
    // Pipeline freeze conditions
    //////////////////////////////////////////////////////////////////////

    // Output side back-pressure freezes every stage
    assign hold = full && !out_ready;

    // Operand hazard or multiply in flight
    assign stall = (read_valid && !operands_ok) || busy;

    assign in_ready = !stall && !hold;

    //////////////////////////////////////////////////////////////////////
    // Read stage occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RST) begin
            read_valid <= 1'b0;
        end else if (in_ready) begin
            read_valid <= in_valid;                 // Taken only on handshake
        end
    end

endmodule

// File: hdl/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic                CLK,
    input  logic                RST,

    input  logic                in_valid,
    output logic                in_ready,
    input  core_pkg::instr_t    in_instr,

    output logic                out_valid,
    input  logic                out_ready,
    output core_pkg::result_t   out_result
);

    logic                stall;
    logic                hold;
    logic                read_valid;
    logic                busy;
    logic                ex_done;
    logic                full;
    logic                operands_ok;

    core_pkg::operands_t operands;
    core_pkg::fwd_t      exec_fwd;
    core_pkg::fwd_t      cushion_fwd;
    core_pkg::fwd_t      wb_fwd;
    core_pkg::result_t   ex_result;

    // rs2 is ignored for immediate forms
    assign operands_ok = operands.rs1_valid &&
                         (operands.rs2_valid || operands.instr.use_imm);

    stage_ctrl ctrl_i (
        .CLK         (CLK),
        .RST         (RST),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .operands_ok (operands_ok),
        .busy        (busy),
        .full        (full),
        .out_ready   (out_ready),
        .stall       (stall),
        .hold        (hold),
        .read_valid  (read_valid)
    );

    reg_file_fwd rf_i (
        .CLK         (CLK),
        .RST         (RST),
        .stall       (stall),
        .hold        (hold),
        .instr       (in_instr),
        .exec_fwd    (exec_fwd),
        .cushion_fwd (cushion_fwd),
        .wb_fwd      (wb_fwd),
        .operands    (operands)
    );

    exec_unit ex_i (
        .CLK         (CLK),
        .RST         (RST),
        .stall       (stall),
        .hold        (hold),
        .read_valid  (read_valid),
        .operands    (operands),
        .exec_fwd    (exec_fwd),
        .ex_result   (ex_result),
        .ex_done     (ex_done),
        .busy        (busy)
    );

    writeback_stage wb_i (
        .CLK         (CLK),
        .RST         (RST),
        .hold        (hold),
        .ex_result   (ex_result),
        .ex_done     (ex_done),
        .cushion_fwd (cushion_fwd),
        .wb_fwd      (wb_fwd),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .full        (full)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic CLK,
    output logic RST
);

    localparam int half_period  = 2;            // 4 ns clock
    localparam int reset_cycles = 16;

    initial begin
        CLK = 1'b0;
        forever #half_period CLK = ~CLK;
    end

    initial begin
        RST = 1'b1;
        repeat (reset_cycles) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
    end

endmodule

// File: verification/core_props.sv
`timescale 1ns/100ps

module core_props (
    input logic                CLK,
    input logic                RST,
    input logic                stall,
    input logic                out_valid,
    input logic                out_ready,
    input core_pkg::result_t   out_result,
    input core_pkg::operands_t operands
);

    // Output entry held until accepted
    out_stable_a: assert property (@(posedge CLK) disable iff (RST)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
        else $error("out_result changed while waiting for out_ready");

    // Stalled instruction neither replaced nor lost
    stall_keeps_instr_a: assert property (@(posedge CLK) disable iff (RST)
        stall |=> $stable(operands.instr))
        else $error("Read stage instruction changed during a stall");

    // x0 reads zero however often it was a destination
    x0_rs1_zero_a: assert property (@(posedge CLK) disable iff (RST)
        (operands.instr.rs1 == '0) |-> (operands.rs1_data == '0))
        else $error("Register 0 read back nonzero on rs1");

    x0_rs2_zero_a: assert property (@(posedge CLK) disable iff (RST)
        (operands.instr.rs2 == '0) |-> (operands.rs2_data == '0))
        else $error("Register 0 read back nonzero on rs2");

endmodule

// File: verification/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    typedef struct packed {
        core_pkg::instr_t instr;
        core_pkg::word_t  expected;
    } entry_t;

    localparam int accept_limit = 200;          // Cycles waiting for in_ready
    localparam int result_limit = 400;          // Cycles waiting for one result
    localparam int reset_limit  = 64;

    logic              CLK;
    logic              RST;
    logic              in_valid;
    logic              in_ready;
    core_pkg::instr_t  in_instr;
    logic              out_valid;
    logic              out_ready;
    core_pkg::result_t out_result;

    entry_t stim_table[$];
    int     check_count;
    int     error_count;
    int     timeout_count;
    logic   collect_done;

    tb_clk_gen clk_gen_i (.CLK(CLK), .RST(RST));

    core_top dut_i (
        .CLK        (CLK),
        .RST        (RST),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    bind core_top core_props props_i (
        .CLK        (CLK),
        .RST        (RST),
        .stall      (stall),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .operands   (operands)
    );

    //////////////////////////////////////////////////////////////////////
    // Instruction table
    //////////////////////////////////////////////////////////////////////
    task automatic add_entry(
        input core_pkg::alu_op_e              op,
        input core_pkg::reg_addr_t            rd,
        input core_pkg::reg_addr_t            rs1,
        input core_pkg::reg_addr_t            rs2,
        input logic [core_pkg::imm_width-1:0] imm,
        input logic                           use_imm,
        input core_pkg::word_t                expected
    );
        entry_t e;
        e.instr    = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, use_imm: use_imm};
        e.expected = expected;
        stim_table.push_back(e);
    endtask

    task automatic load_table();
        // Immediates from x0
        add_entry(core_pkg::ADD, 5'd1,  5'd0,  5'd0,  12'h123, 1'b1, 32'h0000_0123);
        add_entry(core_pkg::ADD, 5'd2,  5'd0,  5'd0,  12'hfff, 1'b1, 32'hffff_ffff);
        add_entry(core_pkg::XOR, 5'd3,  5'd0,  5'd0,  12'h555, 1'b1, 32'h0000_0555);
        add_entry(core_pkg::OR,  5'd4,  5'd0,  5'd0,  12'h800, 1'b1, 32'hffff_f800);
        add_entry(core_pkg::SUB, 5'd5,  5'd0,  5'd0,  12'h001, 1'b1, 32'hffff_ffff);
        add_entry(core_pkg::SLT, 5'd6,  5'd0,  5'd0,  12'h7ff, 1'b1, 32'h0000_0001);
        // Dependent chain through execute, cushion and writeback
        add_entry(core_pkg::SLL, 5'd8,  5'd1,  5'd0,  12'h004, 1'b1, 32'h0000_1230);
        add_entry(core_pkg::ADD, 5'd9,  5'd8,  5'd8,  12'h000, 1'b0, 32'h0000_2460);
        add_entry(core_pkg::SUB, 5'd10, 5'd9,  5'd8,  12'h000, 1'b0, 32'h0000_1230);
        add_entry(core_pkg::XOR, 5'd11, 5'd9,  5'd8,  12'h000, 1'b0, 32'h0000_3650);
        add_entry(core_pkg::ADD, 5'd12, 5'd11, 5'd10, 12'h000, 1'b0, 32'h0000_4880);
        add_entry(core_pkg::SRL, 5'd13, 5'd2,  5'd6,  12'h000, 1'b0, 32'h7fff_ffff);
        add_entry(core_pkg::SLT, 5'd14, 5'd4,  5'd13, 12'h000, 1'b0, 32'h0000_0001);
        add_entry(core_pkg::SLL, 5'd16, 5'd12, 5'd14, 12'h000, 1'b0, 32'h0000_9100);
        add_entry(core_pkg::OR,  5'd17, 5'd16, 5'd3,  12'h000, 1'b0, 32'h0000_9555);
        add_entry(core_pkg::AND, 5'd18, 5'd17, 5'd0,  12'h0ff, 1'b1, 32'h0000_0055);
        // Multiplies with dependent readers
        add_entry(core_pkg::MUL, 5'd19, 5'd17, 5'd0,  12'h003, 1'b1, 32'h0001_bfff);
        add_entry(core_pkg::ADD, 5'd20, 5'd19, 5'd18, 12'h000, 1'b0, 32'h0001_c054);
        add_entry(core_pkg::MUL, 5'd21, 5'd2,  5'd5,  12'h000, 1'b0, 32'h0000_0001);
        add_entry(core_pkg::SUB, 5'd22, 5'd21, 5'd20, 12'h000, 1'b0, 32'hfffe_3fad);
        add_entry(core_pkg::MUL, 5'd23, 5'd1,  5'd0,  12'hffe, 1'b1, 32'hffff_fdba);
        add_entry(core_pkg::XOR, 5'd24, 5'd23, 5'd21, 12'h000, 1'b0, 32'hffff_fdbb);
        // x0 as destination, then as source
        add_entry(core_pkg::ADD, 5'd0,  5'd1,  5'd0,  12'h00f, 1'b1, 32'h0000_0132);
        add_entry(core_pkg::ADD, 5'd25, 5'd0,  5'd1,  12'h000, 1'b0, 32'h0000_0123);
        add_entry(core_pkg::OR,  5'd0,  5'd3,  5'd0,  12'h0aa, 1'b1, 32'h0000_05ff);
        add_entry(core_pkg::SUB, 5'd26, 5'd3,  5'd0,  12'h000, 1'b0, 32'h0000_0555);
        add_entry(core_pkg::MUL, 5'd0,  5'd1,  5'd0,  12'h002, 1'b1, 32'h0000_0246);
        add_entry(core_pkg::ADD, 5'd27, 5'd0,  5'd0,  12'h000, 1'b0, 32'h0000_0000);
        add_entry(core_pkg::SLT, 5'd29, 5'd0,  5'd0,  12'h001, 1'b1, 32'h0000_0001);
        add_entry(core_pkg::ADD, 5'd30, 5'd11, 5'd16, 12'h000, 1'b0, 32'h0000_c750);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream drivers and result checker
    //////////////////////////////////////////////////////////////////////
    task automatic send_all();
        int   waited;
        logic taken;
        foreach (stim_table[i]) begin
            in_valid = 1'b1;
            in_instr = stim_table[i].instr;
            waited   = 0;
            taken    = 1'b0;
            while (!taken && waited < accept_limit) begin
                #1;
                taken = in_ready;               // Transfer on the coming rising edge
                @(negedge CLK);
                waited++;
            end
            if (!taken) begin
                timeout_count++;
                $display("Input handshake timed out at entry %0d, time %0t", i, $time);
                break;
            end
        end
        in_valid = 1'b0;
        in_instr = '0;
    endtask

    task automatic collect_all();
        int                waited;
        logic              got;
        core_pkg::result_t res;
        foreach (stim_table[i]) begin
            waited = 0;
            got    = 1'b0;
            while (!got && waited < result_limit) begin
                #1;
                got = out_valid && out_ready;
                res = out_result;
                @(negedge CLK);
                waited++;
            end
            if (!got) begin
                timeout_count++;
                $display("No result for entry %0d within %0d cycles", i, result_limit);
                break;
            end
            check_count++;
            assert (res.rd == stim_table[i].instr.rd) else begin
                error_count++;
                $display("ERROR %0t: out_result.rd = %0d, expected %0d",
                         $time, res.rd, stim_table[i].instr.rd);
            end
            assert (res.data == stim_table[i].expected) else begin
                error_count++;
                $display("ERROR %0t: out_result.data = %h, expected %h",
                         $time, res.data, stim_table[i].expected);
            end
        end
        collect_done = 1'b1;
    endtask

    task automatic toggle_out_ready();
        int cycles;
        cycles = 0;
        while (!collect_done && cycles < result_limit * stim_table.size()) begin
            out_ready = (($urandom % 3) != 0);  // Low about a third of the time
            @(negedge CLK);
            cycles++;
        end
        out_ready = 1'b1;
    endtask

    initial begin
        int waited;
        in_valid      = 1'b0;
        in_instr      = '0;
        out_ready     = 1'b0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        collect_done  = 1'b0;
        waited        = 0;
        void'($urandom(32'he40f359b));
        load_table();

        do begin
            @(posedge CLK);
            waited++;
        end while (RST && waited < reset_limit);

        if (RST) begin
            timeout_count++;
            $display("Reset was never released");
        end else begin
            @(negedge CLK);
            #1;
            assert (in_ready && !out_valid) else begin
                error_count++;
                $display("ERROR %0t: in_ready = %b, out_valid = %b, expected 1 and 0",
                         $time, in_ready, out_valid);
            end
            @(negedge CLK);
            fork
                send_all();
                collect_all();
                toggle_out_ready();
            join
            repeat (8) begin                    // Nothing extra may follow
                @(negedge CLK);
                #1;
                assert (!out_valid) else begin
                    error_count++;
                    $display("ERROR %0t: out_valid = %b, expected 0", $time, out_valid);
                end
            end
        end

        $display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/core_pkg.sv
hdl/reg_file_fwd.sv
hdl/exec_unit.sv
hdl/writeback_stage.sv
hdl/stage_ctrl.sv
hdl/core_top.sv
verification/tb_clk_gen.sv
verification/core_props.sv
verification/core_tb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module core_tb -f verilog.f -o core_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/core_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
